// ==== verilog/pipe_cfg_pkg.sv ====
`default_nettype none

package pipe_cfg_pkg;

    // Decode queue entries and the number of credits fetch starts with
    localparam int QUEUE_DEPTH = 4;

    // Credit counter has to hold 0 to QUEUE_DEPTH
    localparam int CREDIT_W = 3;

    // Queue pointers and occupancy
    localparam int PTR_W   = 2;
    localparam int COUNT_W = 3;

    // Payload field widths
    localparam int TAG_W   = 8;
    localparam int WORD_W  = 32;
    localparam int CYCLE_W = 16;
    localparam int STALL_W = 4;

endpackage

`default_nettype wire

// ==== verilog/pipe_types_pkg.sv ====
`default_nettype none

package pipe_types_pkg;

    // Raw instruction word that is never decoded
    typedef logic [pipe_cfg_pkg::WORD_W-1:0] instr_word_t;

    // Sequence tag wraps modulo 256
    typedef logic [pipe_cfg_pkg::TAG_W-1:0] seq_tag_t;

    // Free running cycle stamp
    typedef logic [pipe_cfg_pkg::CYCLE_W-1:0] cycle_t;

    // Saturating count of stalled decode cycles
    typedef logic [pipe_cfg_pkg::STALL_W-1:0] stall_cnt_t;

    // 56-bit packet from fetch through the decode queue
    typedef struct packed {
        seq_tag_t    tag;
        instr_word_t word;
        cycle_t      fetch_cycle;
    } fetch_pkt_t;

    // 60-bit record leaving writeback
    typedef struct packed {
        seq_tag_t    tag;
        instr_word_t word;
        cycle_t      fetch_cycle;
        stall_cnt_t  decode_stalls;
    } retire_rec_t;

endpackage

`default_nettype wire

// ==== verilog/pipe_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_fetch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  pipe_types_pkg::instr_word_t instr_word,
    output logic                        instr_ready,
    output logic                        push_valid,
    output pipe_types_pkg::fetch_pkt_t  push_pkt,
    input  logic                        credit_return
);

    logic [pipe_cfg_pkg::CREDIT_W-1:0] credit_cnt;
    pipe_types_pkg::seq_tag_t          next_tag;
    pipe_types_pkg::cycle_t            cycle_cnt;
    logic                              accept;

    // A free credit guarantees room in the queue
    assign instr_ready = (credit_cnt != '0);
    assign accept      = instr_valid && instr_ready;

    // Cycle stamp is zero during reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // Credits are spent at acceptance and come back on each pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= pipe_cfg_pkg::CREDIT_W'(pipe_cfg_pkg::QUEUE_DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Tag counter and push strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            next_tag   <= '0;
            push_valid <= 1'b0;
        end else begin
            push_valid <= accept;
            if (accept) begin
                next_tag <= next_tag + 1'b1;
            end
        end
    end

    // Packet payload is stamped with the count before this edge's increment
    always_ff @(posedge clk) begin
        if (accept) begin
            push_pkt.tag         <= next_tag;
            push_pkt.word        <= instr_word;
            push_pkt.fetch_cycle <= cycle_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_queue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       push_valid,
    input  pipe_types_pkg::fetch_pkt_t push_pkt,
    output logic                       head_valid,
    output pipe_types_pkg::fetch_pkt_t head_pkt,
    input  logic                       pop,
    output logic                       credit_return
);

    localparam int                     DEPTH    = pipe_cfg_pkg::QUEUE_DEPTH;
    localparam int                     PTR_W    = pipe_cfg_pkg::PTR_W;
    localparam logic [PTR_W-1:0]       LAST_IDX = PTR_W'(DEPTH - 1);

    pipe_types_pkg::fetch_pkt_t        mem [DEPTH];
    logic [PTR_W-1:0]                  wr_ptr;
    logic [PTR_W-1:0]                  rd_ptr;
    logic [pipe_cfg_pkg::COUNT_W-1:0]  count;

    assign head_valid = (count != '0);
    assign head_pkt   = mem[rd_ptr];

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_valid) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    // Pointers wrap at the last entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_valid) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Push and pop together leave the occupancy unchanged
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One credit back to fetch per pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/pipe_stages.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_stages (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        head_valid,
    input  pipe_types_pkg::fetch_pkt_t  head_pkt,
    output logic                        pop,
    input  logic                        stall,
    output logic                        retire_valid,
    output pipe_types_pkg::retire_rec_t retire_rec
);

    // Decode slot is empty, loaded this edge, or held by stall at least once
    typedef enum logic [1:0] {
        DEC_EMPTY,
        DEC_BUSY,
        DEC_HELD
    } dec_state_t;

    dec_state_t                  dec_state;
    dec_state_t                  dec_state_nxt;
    pipe_types_pkg::fetch_pkt_t  dec_pkt;
    pipe_types_pkg::stall_cnt_t  dec_stalls;
    logic                        dec_occupied;
    logic                        dec_leave;

    logic                        ex_valid;
    logic                        mem_valid;
    logic                        wb_valid;
    pipe_types_pkg::retire_rec_t ex_rec;
    pipe_types_pkg::retire_rec_t mem_rec;
    pipe_types_pkg::retire_rec_t wb_rec;

    assign dec_occupied = (dec_state != DEC_EMPTY);
    assign dec_leave    = dec_occupied && !stall;

    // Refill decode when it is free or its instruction moves on
    assign pop = head_valid && (!dec_occupied || !stall);

    always_comb begin
        dec_state_nxt = dec_state;
        if (pop) begin
            dec_state_nxt = DEC_BUSY;
        end else if (dec_leave) begin
            dec_state_nxt = DEC_EMPTY;
        end else if (dec_occupied) begin
            dec_state_nxt = DEC_HELD;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_state <= DEC_EMPTY;
        end else begin
            dec_state <= dec_state_nxt;
        end
    end

    // Decode payload and its stall counter that sticks at its maximum
    always_ff @(posedge clk) begin
        if (pop) begin
            dec_pkt    <= head_pkt;
            dec_stalls <= '0;
        end else if (dec_occupied && stall && (dec_stalls != '1)) begin
            dec_stalls <= dec_stalls + 1'b1;
        end
    end

    // Back end valid bits always advance
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= dec_leave;
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    // Record payload follows its valid bit
    always_ff @(posedge clk) begin
        ex_rec.tag           <= dec_pkt.tag;
        ex_rec.word          <= dec_pkt.word;
        ex_rec.fetch_cycle   <= dec_pkt.fetch_cycle;
        ex_rec.decode_stalls <= dec_stalls;
        mem_rec              <= ex_rec;
        wb_rec               <= mem_rec;
    end

    assign retire_valid = wb_valid;
    assign retire_rec   = wb_rec;

endmodule

`default_nettype wire

// ==== verilog/pipe_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  pipe_types_pkg::instr_word_t instr_word,
    output logic                        instr_ready,
    input  logic                        stall,
    output logic                        retire_valid,
    output pipe_types_pkg::retire_rec_t retire_rec
);

    // Fetch to queue
    logic                       push_valid;
    pipe_types_pkg::fetch_pkt_t push_pkt;
    logic                       credit_return;

    // Queue to stages
    logic                       head_valid;
    pipe_types_pkg::fetch_pkt_t head_pkt;
    logic                       pop;

    pipe_fetch u_fetch (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr_word    (instr_word),
        .instr_ready   (instr_ready),
        .push_valid    (push_valid),
        .push_pkt      (push_pkt),
        .credit_return (credit_return)
    );

    pipe_queue u_queue (
        .clk           (clk),
        .rst           (rst),
        .push_valid    (push_valid),
        .push_pkt      (push_pkt),
        .head_valid    (head_valid),
        .head_pkt      (head_pkt),
        .pop           (pop),
        .credit_return (credit_return)
    );

    pipe_stages u_stages (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head_pkt     (head_pkt),
        .pop          (pop),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

endmodule

`default_nettype wire

// ==== tests/pipe_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_checker (
    input logic                              clk,
    input logic                              rst,
    input logic                              push,
    input logic [pipe_cfg_pkg::CREDIT_W-1:0] credits,
    input logic [pipe_cfg_pkg::COUNT_W-1:0]  occupancy,
    input logic                              pop,
    input logic                              credit_return
);

    localparam logic [pipe_cfg_pkg::CREDIT_W-1:0] MAX_CREDITS =
        pipe_cfg_pkg::CREDIT_W'(pipe_cfg_pkg::QUEUE_DEPTH);
    localparam logic [pipe_cfg_pkg::COUNT_W-1:0] MAX_OCCUPANCY =
        pipe_cfg_pkg::COUNT_W'(pipe_cfg_pkg::QUEUE_DEPTH);

    // A push needs a credit and so a free queue entry
    push_needs_credit: assert property (
        @(posedge clk) disable iff (rst) push |-> (credits != '0)
    ) else $error("word pushed while no credit was left");

    credits_in_range: assert property (
        @(posedge clk) disable iff (rst) credits <= MAX_CREDITS
    ) else $error("credit count above the queue depth");

    // Queue never holds more than its depth
    occupancy_in_range: assert property (
        @(posedge clk) disable iff (rst) occupancy <= MAX_OCCUPANCY
    ) else $error("decode queue occupancy above its depth");

    // Each credit pulse follows a real pop from a non-empty queue
    credit_after_pop: assert property (
        @(posedge clk) disable iff (rst)
        credit_return |-> ($past(pop) && ($past(occupancy) != '0))
    ) else $error("credit returned without a pop from a non-empty queue");

endmodule

bind pipe_fetch pipe_checker u_fetch_checker (
    .clk           (clk),
    .rst           (rst),
    .push          (1'b0),
    .credits       (credit_cnt),
    .occupancy     (pipe_cfg_pkg::COUNT_W'(0)),
    .pop           (1'b0),
    .credit_return (1'b0)
);

// Free queue entries stand for the credits fetch has not spent
bind pipe_queue pipe_checker u_queue_checker (
    .clk           (clk),
    .rst           (rst),
    .push          (push_valid),
    .credits       (pipe_cfg_pkg::CREDIT_W'(pipe_cfg_pkg::QUEUE_DEPTH - int'(count))),
    .occupancy     (count),
    .pop           (pop),
    .credit_return (credit_return)
);

`default_nettype wire

// ==== tests/pipe_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_tb;

    localparam int RESET_CYCLES  = 8;
    localparam int WAIT_LIMIT    = 300;
    localparam int SINGLE_WORDS  = 8;
    localparam int BURST_WORDS   = 12;
    localparam int RANDOM_CYCLES = 600;
    localparam int HOLD_CYCLES   = 20;
    localparam int PIPE_LATENCY  = 5;

    logic                        clk;
    logic                        rst;
    logic                        instr_valid;
    pipe_types_pkg::instr_word_t instr_word;
    logic                        instr_ready;
    logic                        stall;
    logic                        retire_valid;
    pipe_types_pkg::retire_rec_t retire_rec;

    // Reference model state with one queue entry per accepted word
    pipe_types_pkg::retire_rec_t exp_q[$];
    int                          accept_edge_q[$];
    int                          stall_seen_q[$];
    pipe_types_pkg::cycle_t      model_cycle;
    pipe_types_pkg::seq_tag_t    model_tag;
    int                          edge_cnt       = 0;
    int                          accepted_total = 0;
    int                          retired_total  = 0;
    int                          error_count    = 0;
    logic                        exact_latency;
    integer                      seed;

    pipe_top u_pipe_top (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_word   (instr_word),
        .instr_ready  (instr_ready),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    always #5 clk = ~clk;

    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_rec(input pipe_types_pkg::retire_rec_t got,
                               input pipe_types_pkg::retire_rec_t exp,
                               input logic check_stalls);
        if (got.tag !== exp.tag) begin
            report_error($sformatf("Mismatch retire_rec.tag: got 0x%h expected 0x%h",
                                   got.tag, exp.tag));
        end
        if (got.word !== exp.word) begin
            report_error($sformatf("Mismatch retire_rec.word: got 0x%h expected 0x%h",
                                   got.word, exp.word));
        end
        if (got.fetch_cycle !== exp.fetch_cycle) begin
            report_error($sformatf("Mismatch retire_rec.fetch_cycle: got 0x%h expected 0x%h",
                                   got.fetch_cycle, exp.fetch_cycle));
        end
        if (check_stalls && (got.decode_stalls !== exp.decode_stalls)) begin
            report_error($sformatf("Mismatch retire_rec.decode_stalls: got 0x%h expected 0x%h",
                                   got.decode_stalls, exp.decode_stalls));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report_error($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // Model follows every edge and reads DUT outputs before the edge's updates
    always @(posedge clk) begin
        pipe_types_pkg::retire_rec_t exp_rec;
        int                          latency;
        int                          stall_bound;
        if (rst) begin
            model_cycle = '0;
            model_tag   = '0;
        end else begin
            edge_cnt++;
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    report_error("A record retired while no accepted word was pending");
                end else begin
                    exp_rec     = exp_q.pop_front();
                    latency     = edge_cnt - accept_edge_q.pop_front() - 1;
                    stall_bound = stall_seen_q.pop_front();
                    if (retired_total == 0) begin
                        compare_count("first retire_rec.tag", int'(retire_rec.tag), 0);
                    end
                    compare_rec(retire_rec, exp_rec, exact_latency);
                    if (int'(retire_rec.decode_stalls) > stall_bound) begin
                        report_error($sformatf(
                            "Mismatch retire_rec.decode_stalls: got 0x%h above bound 0x%0h",
                            retire_rec.decode_stalls, stall_bound));
                    end
                    if (exact_latency) begin
                        compare_count("retire latency", latency, PIPE_LATENCY);
                    end else if (latency < PIPE_LATENCY + int'(retire_rec.decode_stalls)) begin
                        report_error($sformatf("Mismatch retire latency: got 0x%0h below 0x%0h",
                            latency, PIPE_LATENCY + int'(retire_rec.decode_stalls)));
                    end
                    retired_total++;
                end
            end
            if (stall) begin
                foreach (stall_seen_q[i]) begin
                    stall_seen_q[i] = stall_seen_q[i] + 1;
                end
            end
            if (instr_valid && instr_ready) begin
                exp_rec.tag           = model_tag;
                exp_rec.word          = instr_word;
                exp_rec.fetch_cycle   = model_cycle;
                exp_rec.decode_stalls = '0;
                exp_q.push_back(exp_rec);
                accept_edge_q.push_back(edge_cnt);
                stall_seen_q.push_back(0);
                model_tag++;
                accepted_total++;
            end
            model_cycle++;
        end
    end

    // Holds valid until the word is taken at an accepting edge
    task automatic offer_word(input pipe_types_pkg::instr_word_t word);
        int waited;
        waited = 0;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr_word  <= word;
        @(negedge clk);
        while (!instr_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("Timeout: instr_ready never rose for an offered word");
            end
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("Timeout: accepted words did not all retire");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        int accepted_before;
        int waited;
        int retire_seen;
        int first_i;
        int last_i;
        seed          = 32'h6eff_2484;
        clk           = 1'b0;
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instr_word    = '0;
        stall         = 1'b0;
        exact_latency = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_flag("retire_valid", retire_valid, 1'b0);
        compare_flag("instr_ready", instr_ready, 1'b1);

        // Single words into an idle pipeline
        exact_latency = 1'b1;
        for (int i = 0; i < SINGLE_WORDS; i++) begin
            offer_word(pipe_types_pkg::instr_word_t'($random(seed)));
            wait_drained();
        end

        // Back to back with stall low
        accepted_before = accepted_total;
        retire_seen     = 0;
        first_i         = -1;
        last_i          = -1;
        for (int i = 0; i < BURST_WORDS + 8; i++) begin
            @(posedge clk);
            instr_valid <= (i < BURST_WORDS);
            instr_word  <= pipe_types_pkg::instr_word_t'($random(seed));
            @(negedge clk);
            if (i < BURST_WORDS) begin
                compare_flag("instr_ready", instr_ready, 1'b1);
            end
            if (retire_valid) begin
                retire_seen++;
                if (first_i < 0) begin
                    first_i = i;
                end
                last_i = i;
            end
        end
        compare_count("burst accepted count", accepted_total - accepted_before, BURST_WORDS);
        compare_count("burst retired count", retire_seen, BURST_WORDS);
        compare_count("burst retire span", last_i - first_i + 1, BURST_WORDS);
        wait_drained();
        exact_latency = 1'b0;

        // Random traffic and random stall
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            @(posedge clk);
            instr_valid <= (($random(seed) & 3) != 0);
            instr_word  <= pipe_types_pkg::instr_word_t'($random(seed));
            stall       <= (($random(seed) & 7) < 3);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        wait_drained();

        // Back-pressure as the queue fills behind a held decode slot
        accepted_before = accepted_total;
        @(posedge clk);
        stall       <= 1'b1;
        instr_valid <= 1'b1;
        instr_word  <= pipe_types_pkg::instr_word_t'($random(seed));
        waited = 0;
        @(negedge clk);
        while (instr_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_error("Timeout: instr_ready never fell under stall");
            end
            @(posedge clk);
            instr_word <= pipe_types_pkg::instr_word_t'($random(seed));
            @(negedge clk);
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            compare_flag("instr_ready", instr_ready, 1'b0);
        end
        compare_count("accepted under stall", accepted_total - accepted_before,
                      pipe_cfg_pkg::QUEUE_DEPTH + 1);
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        wait_drained();
        @(negedge clk);
        compare_flag("instr_ready", instr_ready, 1'b1);

        compare_count("retired instructions", retired_total, accepted_total);
        compare_count("model queue size", exp_q.size(), 0);
        if (error_count != 0) begin
            $display("Some tests failed");
        end else begin
            $display("All tests passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/pipe_cfg_pkg.sv
verilog/pipe_types_pkg.sv
verilog/pipe_fetch.sv
verilog/pipe_queue.sv
verilog/pipe_stages.sv
verilog/pipe_top.sv
tests/pipe_checker.sv
tests/pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := pipe_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
